//--- vlane.f
+incdir+source
source/vlane_isa_pkg.sv
source/vlane_data_pkg.sv
source/vector_decode.sv
source/vector_regfile.sv
source/valu.sv
source/vlane_top.sv
verification/vlane_props.sv
verification/vlane_tb.sv

//--- Bender.yml
package:
  name: vlane

export_include_dirs:
  - source

sources:
  # lane RTL, packages ahead of the modules that import them
  - include_dirs:
      - source
    files:
      - source/vlane_isa_pkg.sv
      - source/vlane_data_pkg.sv
      - source/vector_decode.sv
      - source/vector_regfile.sv
      - source/valu.sv
      - source/vlane_top.sv

  # testbench and bound properties
  - target: test
    files:
      - verification/vlane_props.sv
      - verification/vlane_tb.sv

//--- verification/vlane_tb.sv
//************************************************************
// lane testbench, LFSR stimulus against a shadow register model
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module vlane_tb;
    import vlane_isa_pkg::*;
    import vlane_data_pkg::*;

    localparam int RESET_LEN = 11;
    localparam int TEST_LEN = 25 + 37 + 37 + 37 + 29 + 29;  // loads, strobes, drain per test
    localparam int TIMEOUT_CYCLES = 2 * (RESET_LEN + TEST_LEN) + 100;

    logic clk = 1'b0;
    logic arst_n, instr_valid, load_valid;
    instr_t instr;
    scalar_t scalar;
    vreg_idx_t load_idx;
    vdata_t load_data;
    logic result_valid;
    vreg_idx_t result_dest;
    vdata_t result_data;

    vdata_t shadow [8];
    vreg_idx_t exp_dest_q [$];
    vdata_t exp_data_q [$];
    int exp_cyc_q [$];
    vreg_idx_t want_dest;
    vdata_t want_data;
    int want_cyc;
    logic [31:0] lfsr_state;
    int cycle_cnt = 0;
    int error_count = 0;
    int errors_at_start = 0;
    int check_count = 0;
    int test_count = 0;

    vlane_top UUT (.*);

    always #20 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic vdata_t ref_result(input valu_op_t op, input sew_t sew,
                                          input vdata_t a, input vdata_t b, input scalar_t s);
        int w;
        vdata_t mask, x, y, r, res;
        if (op == OP_AND_VV) return a & b;  // whole word, element width ignored
        if (op == OP_OR_VV) return a | b;
        if (op == OP_XOR_VV) return a ^ b;
        if (op > OP_XOR_VX || sew > SEW_64) return '0;
        w = 8 << sew;
        mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
        res = '0;
        for (int e = 0; e < 64 / w; e++) begin
            x = (b >> (e * w)) & mask;
            y = op[0] ? (s & mask) : ((a >> (e * w)) & mask);  // odd opcodes use the scalar
            case (op)
                OP_ADD_VV, OP_ADD_VX: r = x + y;
                OP_SUB_VV, OP_SUB_VX: r = x - y;
                OP_MUL_VV, OP_MUL_VX: r = x * y;  // low bits same as signed product
                OP_AND_VX: r = x & y;
                OP_OR_VX: r = x | y;
                default: r = x ^ y;
            endcase
            res = res | ((r & mask) << (e * w));
        end
        return res;
    endfunction

    task automatic load_reg(input vreg_idx_t idx, input vdata_t data);
        @(posedge clk);
        #2;
        instr_valid = 1'b0;
        load_valid = 1'b1;
        load_idx = idx;
        load_data = data;
        shadow[idx] = data;
    endtask

    task automatic load_random_regs();
        for (int i = 0; i < 8; i++) load_reg(vreg_idx_t'(i), rand_bits(64));
    endtask

    task automatic issue(input valu_op_t op, input sew_t sew, input vreg_idx_t vd,
                         input vreg_idx_t vs1, input vreg_idx_t vs2, input scalar_t s);
        @(posedge clk);
        #2;
        load_valid = 1'b0;
        instr_valid = 1'b1;
        instr = {op, sew, vd, vs1, vs2};
        scalar = s;
        shadow[vd] = ref_result(op, sew, shadow[vs1], shadow[vs2], s);
        exp_dest_q.push_back(vd);
        exp_data_q.push_back(shadow[vd]);
        exp_cyc_q.push_back(cycle_cnt + 2);
    endtask

    task automatic issue_rand_regs(input valu_op_t op, input sew_t sew, input scalar_t s);
        vreg_idx_t vd, vs1, vs2;
        vd = vreg_idx_t'(rand_bits(3));
        vs1 = vreg_idx_t'(rand_bits(3));
        vs2 = vreg_idx_t'(rand_bits(3));
        issue(op, sew, vd, vs1, vs2, s);
    endtask

    task automatic drain();
        @(posedge clk);
        #2;
        instr_valid = 1'b0;
        load_valid = 1'b0;
        while (exp_dest_q.size() != 0) @(posedge clk);
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, error_count - errors_at_start);
        errors_at_start = error_count;
    endtask

    always @(negedge clk) begin
        if (!arst_n) begin
            assert (!result_valid) else begin
                $display("ERROR at %0t: result_valid high during reset", $time);
                error_count++;
            end
        end else if (result_valid) begin
            check_count++;
            assert (exp_dest_q.size() != 0) else begin
                $display("ERROR at %0t: result with no instruction outstanding", $time);
                error_count++;
            end
            if (exp_dest_q.size() != 0) begin
                want_dest = exp_dest_q.pop_front();
                want_data = exp_data_q.pop_front();
                want_cyc = exp_cyc_q.pop_front();
                assert (want_cyc == cycle_cnt) else begin
                    $display("ERROR at %0t: result came %s, in cycle %0d instead of %0d",
                             $time, (cycle_cnt < want_cyc) ? "early" : "late", cycle_cnt, want_cyc);
                    error_count++;
                end
                assert (result_dest == want_dest) else begin
                    $display("MISMATCH at %0t: dest v%0d, expected v%0d",
                             $time, result_dest, want_dest);
                    error_count++;
                end
                assert (result_data === want_data) else begin
                    $display("MISMATCH at %0t: v%0d data %h, expected %h",
                             $time, want_dest, result_data, want_data);
                    error_count++;
                end
            end
        end else if (exp_cyc_q.size() != 0 && exp_cyc_q[0] <= cycle_cnt) begin
            assert (1'b0) else begin
                $display("ERROR at %0t: no result for v%0d in cycle %0d",
                         $time, exp_dest_q[0], exp_cyc_q[0]);
                error_count++;
            end
            void'(exp_dest_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_cyc_q.pop_front());
        end
    end

    initial begin : watchdog
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("ERROR: run stopped after %0d cycles without finishing", cycle_cnt);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        valu_op_t arith_vv [3];
        valu_op_t vx_ops [6];
        valu_op_t logic_vv [3];
        valu_op_t op_r;
        sew_t sew_r;
        vreg_idx_t prev, nxt, vs1_r;
        arith_vv = '{OP_ADD_VV, OP_SUB_VV, OP_MUL_VV};
        vx_ops = '{OP_ADD_VX, OP_SUB_VX, OP_MUL_VX, OP_AND_VX, OP_OR_VX, OP_XOR_VX};
        logic_vv = '{OP_AND_VV, OP_OR_VV, OP_XOR_VV};
        lfsr_state = 32'd91548;
        foreach (shadow[i]) shadow[i] = '0;
        instr_valid = 1'b0;
        instr = '0;
        scalar = '0;
        load_valid = 1'b0;
        load_idx = '0;
        load_data = '0;
        arst_n = 1'b1;
        #1 arst_n = 1'b0;  // clean falling edge for the async reset
        repeat (10) @(posedge clk);
        #2 arst_n = 1'b1;

        repeat (4) @(posedge clk);  // any result here has no instruction behind it
        load_random_regs();
        for (int i = 0; i < 8; i++) issue(OP_OR_VX, SEW_64, vreg_idx_t'(i), '0, vreg_idx_t'(i), '0);
        drain();
        report_test("reset and load readback");

        load_random_regs();
        for (int s = 0; s < 4; s++)
            foreach (arith_vv[k]) repeat (2) issue_rand_regs(arith_vv[k], sew_t'(s), '0);
        drain();
        report_test("vector-vector arithmetic");

        load_random_regs();
        for (int s = 0; s < 4; s++)
            foreach (vx_ops[k]) issue_rand_regs(vx_ops[k], sew_t'(s), rand_bits(64));
        drain();
        report_test("vector-scalar ops");

        load_random_regs();
        foreach (logic_vv[k])
            for (int s = 0; s < 8; s++)
                issue(logic_vv[k], sew_t'(s), vreg_idx_t'(3 + s % 5), 3'd1, 3'd2, '0);
        drain();
        report_test("vector-vector logic");

        load_random_regs();
        prev = vreg_idx_t'(rand_bits(3));
        for (int i = 0; i < 16; i++) begin
            op_r = valu_op_t'(rand_bits(4) % 12);
            sew_r = sew_t'(rand_bits(2));
            nxt = vreg_idx_t'(rand_bits(3));
            vs1_r = vreg_idx_t'(rand_bits(3));
            issue(op_r, sew_r, nxt, vs1_r, prev, rand_bits(64));  // vs2 is last destination
            prev = nxt;
        end
        drain();
        report_test("dependent chain");

        load_random_regs();
        for (int i = 0; i < 4; i++)
            issue(valu_op_t'(12 + i), sew_t'(rand_bits(2)), vreg_idx_t'(i), 3'd5, 3'd6, '1);
        for (int i = 0; i < 4; i++)
            issue(vx_ops[i], sew_t'(4 + i), vreg_idx_t'(4 + i), 3'd1, 3'd2, '1);
        for (int i = 0; i < 8; i++) issue(OP_OR_VX, SEW_64, vreg_idx_t'(i), '0, vreg_idx_t'(i), '0);
        drain();
        report_test("illegal opcode and sew");

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/vlane_props.sv
//************************************************************
// timing and reset properties, bound into every vlane_top
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module vlane_props (
    input  logic clk,
    input  logic arst_n,
    input  logic instr_valid,
    input  logic load_valid,
    input  logic result_valid
);

    // fixed two cycle latency, both directions
    a_result_follows: assert property (@(posedge clk) disable iff (!arst_n)
        instr_valid |-> ##2 result_valid)
        else $error("no result two cycles after an instruction strobe");

    a_result_has_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        result_valid |-> $past(instr_valid, 2))
        else $error("result without an instruction strobe two cycles before");

    a_quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> !result_valid)
        else $error("result_valid high while reset is asserted");

    // strobe cycle, issue cycle and result cycle all count as in flight
    a_load_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
        load_valid |-> !(instr_valid || $past(instr_valid) || $past(instr_valid, 2)))
        else $error("register load while an instruction is in flight");

endmodule

bind vlane_top vlane_props u_props (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .load_valid  (load_valid),
    .result_valid(result_valid)
);

`default_nettype wire

//--- source/vlane_top.sv
//************************************************************
// vector lane top, decode feeding the register file and ALU,
// result leaves two cycles after the instruction strobe
//************************************************************
`timescale 1ns/1ps
`default_nettype none

module vlane_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      instr_valid,
    input  vlane_isa_pkg::instr_t     instr,
    input  vlane_data_pkg::scalar_t   scalar,
    input  logic                      load_valid,
    input  vlane_data_pkg::vreg_idx_t load_idx,
    input  vlane_data_pkg::vdata_t    load_data,
    output logic                      result_valid,
    output vlane_data_pkg::vreg_idx_t result_dest,
    output vlane_data_pkg::vdata_t    result_data
);
    import vlane_isa_pkg::*;
    import vlane_data_pkg::*;

    logic      iss_valid;
    valu_op_t  iss_op;
    sew_t      iss_sew;
    vreg_idx_t iss_vd;
    scalar_t   iss_scalar;
    vreg_idx_t rd_idx_a;
    vreg_idx_t rd_idx_b;
    vdata_t    rd_data_a;
    vdata_t    rd_data_b;
    logic      wb_valid;
    vreg_idx_t wb_idx;
    vdata_t    wb_data;

    vector_decode u_decode (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr_valid(instr_valid),
        .instr      (instr),
        .scalar     (scalar),
        .iss_valid  (iss_valid),
        .iss_op     (iss_op),
        .iss_sew    (iss_sew),
        .iss_vd     (iss_vd),
        .iss_scalar (iss_scalar),
        .rd_idx_a   (rd_idx_a),
        .rd_idx_b   (rd_idx_b)
    );

    vector_regfile u_regfile (
        .clk       (clk),
        .arst_n    (arst_n),
        .load_valid(load_valid),
        .load_idx  (load_idx),
        .load_data (load_data),
        .wb_valid  (wb_valid),
        .wb_idx    (wb_idx),
        .wb_data   (wb_data),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    valu u_valu (
        .clk       (clk),
        .arst_n    (arst_n),
        .iss_valid (iss_valid),
        .iss_op    (iss_op),
        .iss_sew   (iss_sew),
        .iss_vd    (iss_vd),
        .iss_scalar(iss_scalar),
        .src_a     (rd_data_a),  // vs1
        .src_b     (rd_data_b),  // vs2
        .wb_valid  (wb_valid),
        .wb_idx    (wb_idx),
        .wb_data   (wb_data)
    );

    assign result_valid = wb_valid;
    assign result_dest  = wb_idx;
    assign result_data  = wb_data;

endmodule

`default_nettype wire

//--- source/valu.sv
//************************************************************
// execute stage, SEW sliced packed SIMD ALU with a result
// register that feeds writeback and the lane result port
//************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "vlane_macros.svh"

module valu (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      iss_valid,
    input  vlane_isa_pkg::valu_op_t   iss_op,
    input  vlane_isa_pkg::sew_t       iss_sew,
    input  vlane_data_pkg::vreg_idx_t iss_vd,
    input  vlane_data_pkg::scalar_t   iss_scalar,
    input  vlane_data_pkg::vdata_t    src_a,
    input  vlane_data_pkg::vdata_t    src_b,
    output logic                      wb_valid,
    output vlane_data_pkg::vreg_idx_t wb_idx,
    output vlane_data_pkg::vdata_t    wb_data
);
    import vlane_isa_pkg::*;
    import vlane_data_pkg::*;

    localparam int NUM_SEW = 4;     // SEW_8 up to SEW_64

    logic       is_vx;
    logic       sew_ok;
    logic [1:0] sew_sel;

    vdata_t     scal_rep [NUM_SEW];
    vdata_t     sum_s    [NUM_SEW];
    vdata_t     diff_s   [NUM_SEW];
    vdata_t     prod_s   [NUM_SEW];
    vdata_t     result;

    assign is_vx   = iss_op[0];     // odd opcodes take the scalar
    assign sew_ok  = (iss_sew <= SEW_64);
    assign sew_sel = iss_sew[1:0];

    // one arithmetic slice set per element width, picked later by sew_sel
    for (genvar g = 0; g < NUM_SEW; g++) begin : g_sew
        localparam int W = 8 << g;
        localparam int N = `VLANE_VLEN / W;

        vdata_t opnd;
        vdata_t sum_w;
        vdata_t diff_w;
        vdata_t prod_w;

        assign scal_rep[g] = {N{iss_scalar[W-1:0]}};   // upper scalar bits dropped
        assign opnd        = is_vx ? scal_rep[g] : src_a;

        always_comb begin
            logic signed [2*W-1:0] full;
            for (int e = 0; e < N; e++) begin
                sum_w[e*W +: W]  = src_b[e*W +: W] + opnd[e*W +: W];
                diff_w[e*W +: W] = src_b[e*W +: W] - opnd[e*W +: W];
                full             = $signed(src_b[e*W +: W]) * $signed(opnd[e*W +: W]);
                prod_w[e*W +: W] = full[W-1:0];     // low half only
            end
        end

        assign sum_s[g]  = sum_w;
        assign diff_s[g] = diff_w;
        assign prod_s[g] = prod_w;
    end

    always_comb begin
        result = '0;
        case (iss_op)
            OP_ADD_VV, OP_ADD_VX: begin
                if (sew_ok) result = sum_s[sew_sel];
            end
            OP_SUB_VV, OP_SUB_VX: begin
                if (sew_ok) result = diff_s[sew_sel];   // vs2 minus other operand
            end
            OP_MUL_VV, OP_MUL_VX: begin
                if (sew_ok) result = prod_s[sew_sel];
            end
            OP_AND_VV: result = src_a & src_b;          // whole word, any sew
            OP_AND_VX: begin
                if (sew_ok) result = src_b & scal_rep[sew_sel];
            end
            OP_OR_VV:  result = src_a | src_b;
            OP_OR_VX: begin
                if (sew_ok) result = src_b | scal_rep[sew_sel];
            end
            OP_XOR_VV: result = src_a ^ src_b;
            OP_XOR_VX: begin
                if (sew_ok) result = src_b ^ scal_rep[sew_sel];
            end
            default:   result = '0;     // opcodes 12..15
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            wb_idx  <= iss_vd;
            wb_data <= result;
        end
    end

endmodule

`default_nettype wire

//--- source/vector_regfile.sv
//************************************************************
// vector register file, external load port plus ALU writeback,
// two combinational read ports that forward the writeback
//************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "vlane_macros.svh"

module vector_regfile (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      load_valid,
    input  vlane_data_pkg::vreg_idx_t load_idx,
    input  vlane_data_pkg::vdata_t    load_data,
    input  logic                      wb_valid,
    input  vlane_data_pkg::vreg_idx_t wb_idx,
    input  vlane_data_pkg::vdata_t    wb_data,
    input  vlane_data_pkg::vreg_idx_t rd_idx_a,
    input  vlane_data_pkg::vreg_idx_t rd_idx_b,
    output vlane_data_pkg::vdata_t    rd_data_a,
    output vlane_data_pkg::vdata_t    rd_data_b
);
    import vlane_data_pkg::*;

    vdata_t regs [`VLANE_NUM_VREGS];

    logic   fwd_a;
    logic   fwd_b;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `VLANE_NUM_VREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `VLANE_NUM_VREGS; i++) begin
                if (wb_valid && wb_idx == vreg_idx_t'(i)) begin
                    regs[i] <= wb_data;         // writeback wins a clash
                end else if (load_valid && load_idx == vreg_idx_t'(i)) begin
                    regs[i] <= load_data;
                end
            end
        end
    end

    // bypass covers a dependent instruction issued right behind its producer
    assign fwd_a = wb_valid && (wb_idx == rd_idx_a);
    assign fwd_b = wb_valid && (wb_idx == rd_idx_b);

    assign rd_data_a = fwd_a ? wb_data : regs[rd_idx_a];
    assign rd_data_b = fwd_b ? wb_data : regs[rd_idx_b];

endmodule

`default_nettype wire

//--- source/vector_decode.sv
//************************************************************
// issue stage, latches a strobed instruction and scalar and
// presents its fields plus the source indices for operand read
//************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "vlane_macros.svh"

module vector_decode (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      instr_valid,
    input  vlane_isa_pkg::instr_t     instr,
    input  vlane_data_pkg::scalar_t   scalar,
    output logic                      iss_valid,
    output vlane_isa_pkg::valu_op_t   iss_op,
    output vlane_isa_pkg::sew_t       iss_sew,
    output vlane_data_pkg::vreg_idx_t iss_vd,
    output vlane_data_pkg::scalar_t   iss_scalar,
    output vlane_data_pkg::vreg_idx_t rd_idx_a,
    output vlane_data_pkg::vreg_idx_t rd_idx_b
);
    import vlane_isa_pkg::*;
    import vlane_data_pkg::*;

    localparam int IDX_W   = $bits(vreg_idx_t);
    localparam int OP_LSB  = `VLANE_INSTR_W - `VLANE_OP_W;
    localparam int SEW_LSB = OP_LSB - `VLANE_SEW_W;
    localparam int VD_LSB  = SEW_LSB - IDX_W;
    localparam int VS1_LSB = VD_LSB - IDX_W;
    localparam int VS2_LSB = VS1_LSB - IDX_W;   // lands on bit 0

    instr_t  instr_q;
    scalar_t scalar_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= instr_valid;   // one cycle behind the strobe
        end
    end

    // fields hold until the next strobe
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            instr_q  <= instr;
            scalar_q <= scalar;
        end
    end

    assign iss_op     = instr_q[OP_LSB +: `VLANE_OP_W];
    assign iss_sew    = instr_q[SEW_LSB +: `VLANE_SEW_W];
    assign iss_vd     = instr_q[VD_LSB +: IDX_W];
    assign iss_scalar = scalar_q;

    // source indices go straight to the regfile so data is there at issue
    assign rd_idx_a = instr_q[VS1_LSB +: IDX_W];
    assign rd_idx_b = instr_q[VS2_LSB +: IDX_W];

endmodule

`default_nettype wire

//--- source/vlane_data_pkg.sv
//************************************************************
// data path types for vector words, scalars and reg indices
//************************************************************
`default_nettype none

`include "vlane_macros.svh"

package vlane_data_pkg;

    typedef logic [`VLANE_VLEN-1:0] vdata_t;
    typedef logic [`VLANE_VLEN-1:0] scalar_t;   // same width as a vector word

    typedef logic [$clog2(`VLANE_NUM_VREGS)-1:0] vreg_idx_t;

endpackage

`default_nettype wire

//--- source/vlane_isa_pkg.sv
//************************************************************
// instruction word, opcode and element width encodings
//************************************************************
`default_nettype none

`include "vlane_macros.svh"

package vlane_isa_pkg;

    typedef logic [`VLANE_INSTR_W-1:0] instr_t;
    typedef logic [`VLANE_OP_W-1:0]    valu_op_t;
    typedef logic [`VLANE_SEW_W-1:0]   sew_t;

    // odd codes are the vector-scalar forms
    localparam valu_op_t OP_ADD_VV = 4'd0;
    localparam valu_op_t OP_ADD_VX = 4'd1;
    localparam valu_op_t OP_SUB_VV = 4'd2;
    localparam valu_op_t OP_SUB_VX = 4'd3;
    localparam valu_op_t OP_MUL_VV = 4'd4;
    localparam valu_op_t OP_MUL_VX = 4'd5;
    localparam valu_op_t OP_AND_VV = 4'd6;
    localparam valu_op_t OP_AND_VX = 4'd7;
    localparam valu_op_t OP_OR_VV  = 4'd8;
    localparam valu_op_t OP_OR_VX  = 4'd9;
    localparam valu_op_t OP_XOR_VV = 4'd10;
    localparam valu_op_t OP_XOR_VX = 4'd11;

    localparam sew_t SEW_8  = 3'd0;
    localparam sew_t SEW_16 = 3'd1;
    localparam sew_t SEW_32 = 3'd2;
    localparam sew_t SEW_64 = 3'd3; // codes above this are illegal

endpackage

`default_nettype wire

//--- source/vlane_macros.svh
//************************************************************
// lane sizing and instruction field widths, shared by the
// packages and by RTL that sizes its own loops
//************************************************************
`ifndef VLANE_MACROS_SVH
`define VLANE_MACROS_SVH

`define VLANE_VLEN      64  // bits per vector register
`define VLANE_NUM_VREGS 8
`define VLANE_INSTR_W   16

// instruction fields, top down: op, sew, vd, vs1, vs2
`define VLANE_OP_W      4
`define VLANE_SEW_W     3

`endif
